// File: source/lcd_pkg.sv
package lcd_pkg;

	// string and display geometry
	localparam int STR_BITS   = 256;
	localparam int LINE_CHARS = 16;

	localparam logic [6:0] LINE1_ADDR = 7'h00; // ddram start of line 1
	localparam logic [6:0] LINE2_ADDR = 7'h40; // ddram start of line 2

	// controller commands
	localparam logic [7:0] CMD_FUNCTION_SET = 8'h28; // 4-bit bus, 2 lines, 5x8 font
	localparam logic [7:0] CMD_ENTRY_MODE   = 8'h06; // increment, no shift
	localparam logic [7:0] CMD_DISPLAY_ON   = 8'h0C; // display on, cursor off
	localparam logic [7:0] CMD_CLEAR        = 8'h01;

	// power-on nibbles, sent alone on the upper four data lines
	localparam logic [3:0] INIT_NIBBLE_A = 4'h3;
	localparam logic [3:0] INIT_NIBBLE_B = 4'h2;

	typedef logic [3:0] nibble_t;

	// wait that follows the last nibble of a transfer
	typedef enum logic [2:0] {
		WAIT_POR_LONG,  // ~4.1 ms after first 3
		WAIT_POR_SHORT, // ~100 us after second 3
		WAIT_CMD,       // ~40 us, normal command or data
		WAIT_CLEAR      // ~1.64 ms for clear
	} wait_t;

	typedef struct packed {
		logic       set_ddram; // bit 7 of the set-address command
		logic [6:0] addr;
	} ddram_cmd_t;

	// one byte, seen either as bus nibbles or as a set-address command
	typedef union packed {
		nibble_t [1:0] raw;   // [1] goes out first
		ddram_cmd_t    ddram;
	} lcd_byte_u;

endpackage

// File: source/lcd_nibble_strobe.sv
`timescale 1ns/1ps

module lcd_nibble_strobe
	import lcd_pkg::*;
#(
	parameter int T_SETUP = 16,
	parameter int T_PULSE = 32,
	parameter int T_HOLD  = 16
) (
	input  logic        CCLK,
	input  logic        lcdreset,
	input  logic        start,
	input  nibble_t     nibble,
	input  logic        rs,
	input  logic [18:0] wait_cycles,
	output nibble_t     lcdd,
	output logic        rslcd,
	output logic        elcd,
	output logic        done
);

	localparam logic [2:0] PH_IDLE  = 3'd0;
	localparam logic [2:0] PH_SETUP = 3'd1;
	localparam logic [2:0] PH_PULSE = 3'd2;
	localparam logic [2:0] PH_HOLD  = 3'd3;
	localparam logic [2:0] PH_WAIT  = 3'd4;

	logic [2:0]  phase;
	logic [18:0] count;    // cycles left in current phase, minus one
	logic [18:0] wait_len;

	assign elcd = (phase == PH_PULSE);

	always_ff @(posedge CCLK) begin
		if (start && phase == PH_IDLE) begin
			wait_len <= wait_cycles;
		end
	end

	always_ff @(posedge CCLK) begin
		if (lcdreset) begin
			phase <= PH_IDLE;
			count <= '0;
			lcdd  <= '0;
			rslcd <= 1'b0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (phase)
				PH_IDLE: begin
					if (start) begin
						phase <= PH_SETUP;
						count <= 19'(T_SETUP - 1);
						lcdd  <= nibble; // held until the next start
						rslcd <= rs;
					end
				end
				PH_SETUP: begin
					if (count == '0) begin
						phase <= PH_PULSE;
						count <= 19'(T_PULSE - 1);
					end else begin
						count <= count - 1'b1;
					end
				end
				PH_PULSE: begin
					if (count == '0) begin
						phase <= PH_HOLD;
						count <= 19'(T_HOLD - 1);
					end else begin
						count <= count - 1'b1;
					end
				end
				PH_HOLD: begin
					if (count != '0) begin
						count <= count - 1'b1;
					end else if (wait_len == '0) begin
						phase <= PH_IDLE; // no wait requested
						done  <= 1'b1;
					end else begin
						phase <= PH_WAIT;
						count <= wait_len - 1'b1;
					end
				end
				PH_WAIT: begin
					if (count == '0) begin
						phase <= PH_IDLE;
						done  <= 1'b1;
					end else begin
						count <= count - 1'b1;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

endmodule

// File: source/lcd_byte_writer.sv
`timescale 1ns/1ps

module lcd_byte_writer
	import lcd_pkg::*;
#(
	parameter int T_GAP       = 64,
	parameter int T_CMD       = 2048,
	parameter int T_CLEAR     = 131072,
	parameter int T_POR_SHORT = 8192,
	parameter int T_POR_LONG  = 262144
) (
	input  logic        CCLK,
	input  logic        lcdreset,
	input  logic        byte_start,
	input  lcd_byte_u   byte_val,
	input  logic        is_data,
	input  logic        nibble_only,
	input  wait_t       wait_class,
	output logic        byte_done,
	output logic        nib_start,
	output nibble_t     nib_val,
	output logic        nib_rs,
	output logic [18:0] nib_wait,
	input  logic        nib_done
);

	lcd_byte_u byte_reg;   // keeps the lower nibble for the second strobe
	wait_t     class_reg;
	logic      second_due; // lower nibble still to send

	function automatic logic [18:0] wait_len(input wait_t wc);
		case (wc)
			WAIT_POR_LONG:  return 19'(T_POR_LONG);
			WAIT_POR_SHORT: return 19'(T_POR_SHORT);
			WAIT_CLEAR:     return 19'(T_CLEAR);
			default:        return 19'(T_CMD);
		endcase
	endfunction

	// operands for the strobe, valid with nib_start
	always_ff @(posedge CCLK) begin
		if (byte_start) begin
			byte_reg  <= byte_val;
			class_reg <= wait_class;
			nib_rs    <= is_data; // same rs for both halves
			if (nibble_only) begin
				nib_val  <= byte_val.raw[0];
				nib_wait <= wait_len(wait_class);
			end else begin
				nib_val  <= byte_val.raw[1];
				nib_wait <= 19'(T_GAP); // short gap between halves
			end
		end else if (nib_done && second_due) begin
			nib_val  <= byte_reg.raw[0];
			nib_wait <= wait_len(class_reg);
		end
	end

	always_ff @(posedge CCLK) begin
		if (lcdreset) begin
			nib_start  <= 1'b0;
			byte_done  <= 1'b0;
			second_due <= 1'b0;
		end else begin
			nib_start <= 1'b0;
			byte_done <= 1'b0;
			if (byte_start) begin
				nib_start  <= 1'b1;
				second_due <= !nibble_only;
			end else if (nib_done) begin
				if (second_due) begin
					nib_start  <= 1'b1;
					second_due <= 1'b0;
				end else begin
					byte_done <= 1'b1; // last nibble and its wait are over
				end
			end
		end
	end

endmodule

// File: source/lcd_display_seq.sv
`timescale 1ns/1ps

module lcd_display_seq
	import lcd_pkg::*;
(
	input  logic                CCLK,
	input  logic                lcdreset,
	input  logic [STR_BITS-1:0] strdata,
	output logic                byte_start,
	output lcd_byte_u           byte_val,
	output logic                is_data,
	output logic                nibble_only,
	output wait_t               wait_class,
	input  logic                byte_done,
	output logic                ready
);

	localparam int CHAR_W = $clog2(STR_BITS / 8);

	// step list: 0-3 init nibbles, 4-6 setup, 7 clear, then the two lines
	localparam logic [5:0] STEP_LINE1 = 6'd8;
	localparam logic [5:0] STEP_LINE2 = 6'(8 + LINE_CHARS + 1);
	localparam logic [5:0] STEP_LAST  = 6'(8 + 2 * LINE_CHARS + 1);

	logic [5:0]        step;
	logic [CHAR_W-1:0] char_idx; // byte of strdata, top byte first
	logic              pending;  // waiting for byte_done
	logic [7:0]        cur_char;

	lcd_byte_u next_byte;
	logic      next_data;
	logic      next_nib;
	wait_t     next_wait;

	assign cur_char = strdata[{char_idx, 3'b000} +: 8];

	// decode of the current step
	always_comb begin
		next_byte.raw = '0;
		next_data     = 1'b0;
		next_nib      = 1'b0;
		next_wait     = WAIT_CMD;
		case (step)
			6'd0: begin
				next_byte.raw[0] = INIT_NIBBLE_A;
				next_nib         = 1'b1;
				next_wait        = WAIT_POR_LONG;
			end
			6'd1: begin
				next_byte.raw[0] = INIT_NIBBLE_A;
				next_nib         = 1'b1;
				next_wait        = WAIT_POR_SHORT;
			end
			6'd2: begin
				next_byte.raw[0] = INIT_NIBBLE_A;
				next_nib         = 1'b1;
			end
			6'd3: begin
				next_byte.raw[0] = INIT_NIBBLE_B; // switch to 4-bit bus
				next_nib         = 1'b1;
			end
			6'd4: next_byte.raw = CMD_FUNCTION_SET;
			6'd5: next_byte.raw = CMD_ENTRY_MODE;
			6'd6: next_byte.raw = CMD_DISPLAY_ON;
			6'd7: begin
				next_byte.raw = CMD_CLEAR;
				next_wait     = WAIT_CLEAR;
			end
			STEP_LINE1: begin
				next_byte.ddram.set_ddram = 1'b1;
				next_byte.ddram.addr      = LINE1_ADDR;
			end
			STEP_LINE2: begin
				next_byte.ddram.set_ddram = 1'b1;
				next_byte.ddram.addr      = LINE2_ADDR;
			end
			default: begin
				next_byte.raw = cur_char; // character step
				next_data     = 1'b1;
			end
		endcase
	end

	// operands of the issued byte
	always_ff @(posedge CCLK) begin
		if (!ready && !pending) begin
			byte_val    <= next_byte;
			is_data     <= next_data;
			nibble_only <= next_nib;
			wait_class  <= next_wait;
		end
	end

	always_ff @(posedge CCLK) begin
		if (lcdreset) begin
			step       <= '0;
			char_idx   <= CHAR_W'(STR_BITS / 8 - 1);
			pending    <= 1'b0;
			byte_start <= 1'b0;
			ready      <= 1'b0;
		end else begin
			byte_start <= 1'b0;
			if (!ready && !pending) begin
				byte_start <= 1'b1;
				pending    <= 1'b1;
			end else if (pending && byte_done) begin
				pending <= 1'b0;
				step    <= step + 1'b1;
				if (next_data) begin
					char_idx <= char_idx - 1'b1;
				end
				if (step == STEP_LAST) begin
					ready <= 1'b1; // idle until next reset
				end
			end
		end
	end

endmodule

// File: source/lcd_display.sv
`timescale 1ns/1ps

module lcd_display
	import lcd_pkg::*;
#(
	parameter int T_SETUP     = 16,
	parameter int T_PULSE     = 32,
	parameter int T_HOLD      = 16,
	parameter int T_GAP       = 64,
	parameter int T_CMD       = 2048,
	parameter int T_CLEAR     = 131072,
	parameter int T_POR_SHORT = 8192,
	parameter int T_POR_LONG  = 262144
) (
	input  logic                CCLK,
	input  logic                lcdreset,
	input  logic [STR_BITS-1:0] strdata,
	output logic                rslcd,
	output logic                rwlcd,
	output logic                elcd,
	output nibble_t             lcdd,
	output logic                ready
);

	logic        byte_start;
	lcd_byte_u   byte_val;
	logic        is_data;
	logic        nibble_only;
	wait_t       wait_class;
	logic        byte_done;
	logic        nib_start;
	nibble_t     nib_val;
	logic        nib_rs;
	logic [18:0] nib_wait;
	logic        nib_done;

	assign rwlcd = 1'b0; // write only, no busy readback

	lcd_display_seq i_seq (
		.CCLK        (CCLK),
		.lcdreset    (lcdreset),
		.strdata     (strdata),
		.byte_start  (byte_start),
		.byte_val    (byte_val),
		.is_data     (is_data),
		.nibble_only (nibble_only),
		.wait_class  (wait_class),
		.byte_done   (byte_done),
		.ready       (ready)
	);

	lcd_byte_writer #(
		.T_GAP       (T_GAP),
		.T_CMD       (T_CMD),
		.T_CLEAR     (T_CLEAR),
		.T_POR_SHORT (T_POR_SHORT),
		.T_POR_LONG  (T_POR_LONG)
	) i_writer (
		.CCLK        (CCLK),
		.lcdreset    (lcdreset),
		.byte_start  (byte_start),
		.byte_val    (byte_val),
		.is_data     (is_data),
		.nibble_only (nibble_only),
		.wait_class  (wait_class),
		.byte_done   (byte_done),
		.nib_start   (nib_start),
		.nib_val     (nib_val),
		.nib_rs      (nib_rs),
		.nib_wait    (nib_wait),
		.nib_done    (nib_done)
	);

	lcd_nibble_strobe #(
		.T_SETUP (T_SETUP),
		.T_PULSE (T_PULSE),
		.T_HOLD  (T_HOLD)
	) i_strobe (
		.CCLK        (CCLK),
		.lcdreset    (lcdreset),
		.start       (nib_start),
		.nibble      (nib_val),
		.rs          (nib_rs),
		.wait_cycles (nib_wait),
		.lcdd        (lcdd),
		.rslcd       (rslcd),
		.elcd        (elcd),
		.done        (nib_done)
	);

endmodule

// File: tb/lcd_bus_model.sv
`timescale 1ns/1ps

module lcd_bus_model
	import lcd_pkg::*;
(
	input  logic        CCLK,
	input  logic        lcdreset,
	input  logic        elcd,
	input  logic        rslcd,
	input  nibble_t     lcdd,
	output logic        xfer_valid,
	output logic [7:0]  xfer_byte,
	output logic        xfer_rs,
	output logic [31:0] pulse_count
);

	localparam int LONE_NIBBLES = 4; // power-on nibbles come alone

	logic       elcd_q;
	logic       half_seen;  // upper nibble of a byte already taken
	logic [2:0] lone_count;
	nibble_t    upper;

	always_ff @(posedge CCLK) begin
		if (lcdreset) begin
			elcd_q      <= 1'b0;
			xfer_valid  <= 1'b0;
			half_seen   <= 1'b0;
			lone_count  <= '0;
			pulse_count <= '0;
		end else begin
			elcd_q     <= elcd;
			xfer_valid <= 1'b0;
			if (elcd_q && !elcd) begin // enable just fell, bus still in hold
				pulse_count <= pulse_count + 1;
				if (lone_count < LONE_NIBBLES) begin
					lone_count <= lone_count + 1'b1;
					xfer_byte  <= {4'h0, lcdd};
					xfer_rs    <= rslcd;
					xfer_valid <= 1'b1;
				end else if (!half_seen) begin
					upper     <= lcdd;
					half_seen <= 1'b1;
				end else begin
					xfer_byte  <= {upper, lcdd}; // upper half came first
					xfer_rs    <= rslcd;
					xfer_valid <= 1'b1;
					half_seen  <= 1'b0;
				end
			end
		end
	end

endmodule

// File: tb/lcd_display_asserts.sv
`timescale 1ns/1ps

module lcd_display_asserts
	import lcd_pkg::*;
#(
	parameter int T_PULSE = 32
) (
	input logic    CCLK,
	input logic    lcdreset,
	input logic    elcd,
	input logic    rslcd,
	input logic    rwlcd,
	input nibble_t lcdd,
	input logic    ready
);

	int high_len; // cycles the enable has been high

	always_ff @(posedge CCLK) begin
		if (lcdreset || !elcd) begin
			high_len <= 0;
		end else begin
			high_len <= high_len + 1;
		end
	end

	pulse_width: assert property (@(posedge CCLK) disable iff (lcdreset)
		$fell(elcd) |-> high_len == T_PULSE)
		else $error("enable pulse lasted %0d cycles", high_len);

	bus_stable: assert property (@(posedge CCLK) disable iff (lcdreset)
		(elcd && $past(elcd)) |-> ($stable(lcdd) && $stable(rslcd)))
		else $error("data or rs changed while enable was high");

	write_only: assert property (@(posedge CCLK) !rwlcd)
		else $error("read/write line went high");

	reset_state: assert property (@(posedge CCLK) lcdreset |=> (!elcd && !ready))
		else $error("enable or ready set right after reset");

endmodule

bind lcd_display lcd_display_asserts #(
	.T_PULSE (T_PULSE)
) i_asserts (
	.CCLK     (CCLK),
	.lcdreset (lcdreset),
	.elcd     (elcd),
	.rslcd    (rslcd),
	.rwlcd    (rwlcd),
	.lcdd     (lcdd),
	.ready    (ready)
);

// File: tb/tb_lcd_display.sv
`timescale 1ns/1ps

module tb_lcd_display
	import lcd_pkg::*;
();

	localparam int WAIT_LIMIT   = 2000; // cycles allowed per wait
	localparam int QUIET_CYCLES = 200;
	localparam int ALL_XFERS    = 8 + 2 * (LINE_CHARS + 1);

	logic                CCLK;
	logic                lcdreset;
	logic [STR_BITS-1:0] strdata;
	logic                rslcd;
	logic                rwlcd;
	logic                elcd;
	logic                ready;
	nibble_t             lcdd;
	logic                xfer_valid;
	logic [7:0]          xfer_byte;
	logic                xfer_rs;
	logic [31:0]         pulse_count;

	logic [7:0] got_val[$]; // transfers rebuilt by the bus model
	logic       got_rs[$];
	int         errors;
	int         checks;
	integer     seed;

	lcd_display #(
		.T_SETUP (2), .T_PULSE (3), .T_HOLD (2), .T_GAP (4), .T_CMD (6),
		.T_CLEAR (10), .T_POR_SHORT (8), .T_POR_LONG (12)
	) i_lcd_display (
		.CCLK (CCLK), .lcdreset (lcdreset), .strdata (strdata), .rslcd (rslcd),
		.rwlcd (rwlcd), .elcd (elcd), .lcdd (lcdd), .ready (ready)
	);

	lcd_bus_model i_bus_model (
		.CCLK (CCLK), .lcdreset (lcdreset), .elcd (elcd), .rslcd (rslcd), .lcdd (lcdd),
		.xfer_valid (xfer_valid), .xfer_byte (xfer_byte), .xfer_rs (xfer_rs),
		.pulse_count (pulse_count)
	);

	initial begin
		CCLK = 1'b0;
		forever #50 CCLK = ~CCLK;
	end

	always @(posedge CCLK) begin
		if (xfer_valid) begin
			got_val.push_back(xfer_byte);
			got_rs.push_back(xfer_rs);
		end
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_transfer(input string name, input int idx,
		input logic [7:0] exp_val, input logic exp_rs);
		if (idx >= got_val.size()) begin
			$display("ERROR %s: transfer %0d never appeared on the bus", name, idx);
			errors++;
		end else begin
			compare_value($sformatf("%s byte %0d", name, idx), exp_val, got_val[idx]);
			compare_value($sformatf("%s rs %0d", name, idx), exp_rs, got_rs[idx]);
		end
	endtask

	task automatic wait_transfers(input string name, input int count);
		int cycles;
		cycles = 0;
		while (got_val.size() < count && cycles < WAIT_LIMIT) begin
			@(negedge CCLK);
			cycles++;
		end
		if (got_val.size() < count) begin
			$display("%s: timed out waiting for %0d transfers, saw %0d", name, count,
				got_val.size());
			errors++;
		end
	endtask

	task automatic apply_reset(input string name);
		@(posedge CCLK);
		lcdreset <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			@(negedge CCLK);
			if (i > 0) begin // first edge has not seen reset yet
				compare_value({name, " elcd"}, 0, elcd);
				compare_value({name, " rslcd"}, 0, rslcd);
				compare_value({name, " ready"}, 0, ready);
			end
		end
		got_val.delete();
		got_rs.delete();
		@(posedge CCLK);
		lcdreset <= 1'b0;
		repeat (2) begin
			@(negedge CCLK);
			compare_value({name, " elcd after"}, 0, elcd);
			compare_value({name, " rslcd after"}, 0, rslcd);
			compare_value({name, " ready after"}, 0, ready);
			compare_value({name, " rwlcd after"}, 0, rwlcd);
		end
	endtask

	task automatic test_power_on(input string name);
		logic [7:0] expected [0:7];
		expected = '{{4'h0, INIT_NIBBLE_A}, {4'h0, INIT_NIBBLE_A}, {4'h0, INIT_NIBBLE_A},
			{4'h0, INIT_NIBBLE_B}, CMD_FUNCTION_SET, CMD_ENTRY_MODE, CMD_DISPLAY_ON,
			CMD_CLEAR};
		wait_transfers(name, 8);
		for (int i = 0; i < 8; i++) begin
			check_transfer(name, i, expected[i], 1'b0);
		end
	endtask

	// address command, then 16 characters from top_bit downwards
	task automatic test_line(input string name, input int first, input logic [7:0] addr_cmd,
		input int top_bit);
		wait_transfers(name, first + 1 + LINE_CHARS);
		check_transfer(name, first, addr_cmd, 1'b0);
		for (int i = 0; i < LINE_CHARS; i++) begin
			check_transfer(name, first + 1 + i, strdata[top_bit - 8 * i -: 8], 1'b1);
		end
	endtask

	task automatic test_ready_quiet(input string name);
		int          cycles;
		logic [31:0] pulses;
		cycles = 0;
		while (!ready && cycles < WAIT_LIMIT) begin
			@(negedge CCLK);
			cycles++;
		end
		if (!ready) begin
			$display("%s: ready never went high", name);
			errors++;
		end
		compare_value({name, " transfers"}, ALL_XFERS, got_val.size());
		pulses = pulse_count;
		repeat (QUIET_CYCLES) @(negedge CCLK);
		compare_value({name, " pulses"}, pulses, pulse_count);
		compare_value({name, " ready held"}, 1, ready);
	endtask

	task automatic test_run(input string tag);
		test_power_on({"power_on/", tag});
		test_line({"line1/", tag}, 8, 8'h80, STR_BITS - 1);
		test_line({"line2/", tag}, 9 + LINE_CHARS, 8'hC0, STR_BITS / 2 - 1);
		test_ready_quiet({"idle/", tag});
	endtask

	task automatic test_second_string();
		@(posedge CCLK);
		for (int w = 0; w < STR_BITS / 32; w++) begin
			strdata[w * 32 +: 32] <= $random(seed);
		end
		apply_reset("reset/second");
		test_run("second");
	endtask

	initial begin
		errors   = 0;
		checks   = 0;
		seed     = 32'h7b81_47d1;
		lcdreset = 1'b1;
		strdata  = {"0123456789ABCDEF", "Hello, LCD line2"};
		apply_reset("reset/first");
		test_run("first");
		test_second_string();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: sources.f
source/lcd_pkg.sv
source/lcd_nibble_strobe.sv
source/lcd_byte_writer.sv
source/lcd_display_seq.sv
source/lcd_display.sv
tb/lcd_bus_model.sv
tb/lcd_display_asserts.sv
tb/tb_lcd_display.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lcd testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_lcd_display -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_lcd_display > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
exit 0
